// ==== sim.f ====
common/hashCpuPkg.sv
rtl/hashFunc.sv
rtl/intAlu.sv
rtl/regFile.sv
rtl/hashCtrl.sv
rtl/hashCpu.sv
dv/clkGen.sv
dv/hashCpu_props.sv
dv/tb_hashCpu.sv

// ==== Makefile ====
# Verilator build for the hash processor core

VERILATOR  ?= verilator
TOP        ?= tb_hashCpu
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_hashCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hashCpu;

    logic                          clk;
    logic                          reset;
    logic                          instrReq;
    hashCpuPkg::instr_u            instr;
    logic                          instrAck;
    logic [hashCpuPkg::DATA_W-1:0] result;

    string                         testNames [$];
    hashCpuPkg::instr_u            testInstrs [$];
    logic [hashCpuPkg::DATA_W-1:0] testExpects [$];

    integer                        seed = 32'h7d2d_3355;
    int                            cycleCount = 0;
    int                            cycleLimit = 0;
    int unsigned                   gap;

    clkGen u_clkGen (.clk(clk));

    hashCpu u_dut (
        .clk      (clk),
        .reset    (reset),
        .instrReq (instrReq),
        .instr    (instr),
        .instrAck (instrAck),
        .result   (result)
    );

    ////////////////////
    // Instruction encoders
    ////////////////////
    function automatic hashCpuPkg::instr_u encodeReg(input logic [5:0] opcode, input int rs,
        input int rt, input int rd, input int shamtRu, input logic [5:0] func);
        hashCpuPkg::instr_u word;
        word.rType.opcode  = opcode;
        word.rType.rs      = rs[4:0];
        word.rType.rt      = rt[4:0];
        word.rType.rd      = rd[4:0];
        word.rType.shamtRu = shamtRu[4:0];
        word.rType.func    = func;
        return word;
    endfunction

    function automatic hashCpuPkg::instr_u rTypeWord(input int rs, input int rt, input int rd,
        input int shamt, input logic [5:0] func);
        return encodeReg(hashCpuPkg::OP_RTYPE, rs, rt, rd, shamt, func);
    endfunction

    function automatic hashCpuPkg::instr_u hTypeWord(input int rs, input int rt, input int rd,
        input int ru, input logic [5:0] func);
        return encodeReg(hashCpuPkg::OP_HTYPE, rs, rt, rd, ru, func);
    endfunction

    function automatic hashCpuPkg::instr_u addiWord(input int rs, input int rt, input int imm);
        hashCpuPkg::instr_u word;
        word.iType.opcode = hashCpuPkg::OP_ADDI;
        word.iType.rs     = rs[4:0];
        word.iType.rt     = rt[4:0];
        word.iType.imm    = imm[15:0];
        return word;
    endfunction

    task automatic addTest(input string name, input hashCpuPkg::instr_u word,
                           input logic [hashCpuPkg::DATA_W-1:0] expected);
        testNames.push_back(name);
        testInstrs.push_back(word);
        testExpects.push_back(expected);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////
    task automatic buildTable();
        // Constants, negative immediates sign-extend
        addTest("addi_r1",   addiWord(0, 1, 'h1234), 32'h0000_1234);
        addTest("addi_r2",   addiWord(0, 2, 'hffff), 32'hffff_ffff);
        addTest("addi_r3",   addiWord(0, 3, 'h7fff), 32'h0000_7fff);
        addTest("addi_r4",   addiWord(1, 4, 'h8000), 32'hffff_9234);
        addTest("addi_r5",   addiWord(0, 5, 'h0005), 32'h0000_0005);
        addTest("addi_r6",   addiWord(5, 6, 'hfff9), 32'hffff_fffe);
        // Register ALU ops
        addTest("add",       rTypeWord(1, 3, 7, 0, hashCpuPkg::FN_ADD),  32'h0000_9233);
        addTest("sub",       rTypeWord(1, 3, 8, 0, hashCpuPkg::FN_SUB),  32'hffff_9235);
        addTest("and",       rTypeWord(4, 3, 9, 0, hashCpuPkg::FN_AND),  32'h0000_1234);
        addTest("or",        rTypeWord(1, 3, 10, 0, hashCpuPkg::FN_OR),  32'h0000_7fff);
        addTest("xor",       rTypeWord(2, 1, 11, 0, hashCpuPkg::FN_XOR), 32'hffff_edcb);
        addTest("slt_neg",   rTypeWord(6, 5, 12, 0, hashCpuPkg::FN_SLT), 32'h0000_0001);
        addTest("slt_pos",   rTypeWord(5, 6, 13, 0, hashCpuPkg::FN_SLT), 32'h0000_0000);
        addTest("slt_signd", rTypeWord(2, 0, 14, 0, hashCpuPkg::FN_SLT), 32'h0000_0001);
        // Shifts of 0xffff8001
        addTest("addi_r15",  addiWord(0, 15, 'h8001), 32'hffff_8001);
        addTest("sll_0",     rTypeWord(0, 15, 16, 0, hashCpuPkg::FN_SLL),  32'hffff_8001);
        addTest("sll_1",     rTypeWord(0, 15, 17, 1, hashCpuPkg::FN_SLL),  32'hffff_0002);
        addTest("sll_17",    rTypeWord(0, 15, 18, 17, hashCpuPkg::FN_SLL), 32'h0002_0000);
        addTest("sll_31",    rTypeWord(0, 15, 19, 31, hashCpuPkg::FN_SLL), 32'h8000_0000);
        addTest("srl_0",     rTypeWord(0, 15, 20, 0, hashCpuPkg::FN_SRL),  32'hffff_8001);
        addTest("srl_1",     rTypeWord(0, 15, 21, 1, hashCpuPkg::FN_SRL),  32'h7fff_c000);
        addTest("srl_17",    rTypeWord(0, 15, 22, 17, hashCpuPkg::FN_SRL), 32'h0000_7fff);
        addTest("srl_31",    rTypeWord(0, 15, 23, 31, hashCpuPkg::FN_SRL), 32'h0000_0001);
        // Hash ops with X=r26, Y=r27, Z=r28
        addTest("addi_r26",  addiWord(0, 26, 'h0f0f), 32'h0000_0f0f);
        addTest("addi_r27",  addiWord(0, 27, 'h3355), 32'h0000_3355);
        addTest("addi_r28",  addiWord(0, 28, 'ha5a5), 32'hffff_a5a5);
        addTest("hash_ch",   hTypeWord(26, 27, 24, 28, hashCpuPkg::FN_CH),  32'hffff_a3a5);
        addTest("hash_maj",  hTypeWord(26, 27, 25, 28, hashCpuPkg::FN_MAJ), 32'h0000_2705);
        addTest("hash_par",  hTypeWord(26, 27, 13, 28, hashCpuPkg::FN_PAR), 32'hffff_99ff);
        // r0 and illegal encodings
        addTest("addi_r0",   addiWord(1, 0, 'h0001), 32'h0000_1235);
        addTest("add_r0_r0", rTypeWord(0, 0, 29, 0, hashCpuPkg::FN_ADD), 32'h0000_0000);
        addTest("bad_opcode", encodeReg(6'h3f, 1, 1, 1, 0, hashCpuPkg::FN_ADD), 32'h0000_0000);
        addTest("read_r1",   rTypeWord(1, 0, 30, 0, hashCpuPkg::FN_OR), 32'h0000_1234);
        addTest("bad_func",  rTypeWord(1, 1, 3, 0, 6'h3f), 32'h0000_0000);
        addTest("read_r3",   rTypeWord(3, 0, 31, 0, hashCpuPkg::FN_OR), 32'h0000_7fff);
    endtask

    ////////////////////
    // Four-phase transaction
    ////////////////////
    task automatic runTransaction(input int idx);
        int unsigned holdCycles;
        instr    = testInstrs[idx];
        instrReq = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!instrAck);
        assert (result === testExpects[idx]) else begin
            $display("ERR %s: expected %h actual %h",
                     testNames[idx], testExpects[idx], result);
            $display("Result: FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
        // Host back-pressure, ack and result must hold
        holdCycles = $unsigned($random(seed)) % 3;
        repeat (holdCycles) begin
            @(posedge clk);
            #2;
            assert (instrAck === 1'b1) else begin
                $display("instrAck dropped in %s while the request was still high",
                         testNames[idx]);
                $display("Result: FAILED");
                $fatal(1, "Acknowledge lost during hold");
            end
            assert (result === testExpects[idx]) else begin
                $display("ERR %s: expected %h actual %h",
                         testNames[idx], testExpects[idx], result);
                $display("Result: FAILED");
                $fatal(1, "Stopping at the first mismatch");
            end
        end
        instrReq = 1'b0; // Release after ack
        do begin
            @(posedge clk);
            #2;
        end while (instrAck);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    initial begin
        reset    = 1'b1;
        instrReq = 1'b0;
        instr    = '0;
        buildTable();
        cycleLimit = testNames.size() * 12 + 20;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (!instrAck && result === '0) else begin
            $display("instrAck or result was not cleared by reset");
            $display("Result: FAILED");
            $fatal(1, "Bad state after reset");
        end
        for (int i = 0; i < testNames.size(); i++) begin
            gap = $unsigned($random(seed)) % 4; // Idle gap of 0 to 3 cycles
            if (gap > 0) begin
                repeat (gap) @(posedge clk);
                #2;
            end
            runTransaction(i);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/hashCpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module hashCpu_props (
    input wire logic                          clk,
    input wire logic                          reset,
    input wire logic                          instrReq,
    input wire logic                          instrAck,
    input wire logic [hashCpuPkg::DATA_W-1:0] result
);

    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(instrAck) |-> $past(instrReq)) // Req was high on the edge that raised ack
        else $error("instrAck rose without a request");

    // First edge that samples req high, then two more edges
    ackLatency: assert property (@(posedge clk) disable iff (reset)
        $past(instrReq, 2) && !$past(instrReq, 3) |-> $rose(instrAck))
        else $error("instrAck did not rise two edges after the request");

    resultHeld: assert property (@(posedge clk) disable iff (reset)
        instrAck && $past(instrAck) |-> $stable(result))
        else $error("result changed while instrAck was high");

    ackRelease: assert property (@(posedge clk) disable iff (reset)
        instrAck && !instrReq |=> !instrAck)
        else $error("instrAck stayed high after the request was released");

endmodule

bind hashCpu hashCpu_props u_props (
    .clk      (clk),
    .reset    (reset),
    .instrReq (instrReq),
    .instrAck (instrAck),
    .result   (result)
);

`default_nettype wire

// ==== dv/clkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk; // 20 ns period

endmodule

`default_nettype wire

// ==== rtl/hashCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module hashCpu (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          instrReq,
    input  wire hashCpuPkg::instr_u            instr,
    output logic                               instrAck,
    output logic [hashCpuPkg::DATA_W-1:0]      result
);

    logic [hashCpuPkg::REG_ADDR_W-1:0] rdAddrA;
    logic [hashCpuPkg::REG_ADDR_W-1:0] rdAddrB;
    logic [hashCpuPkg::REG_ADDR_W-1:0] rdAddrC;
    logic [hashCpuPkg::REG_ADDR_W-1:0] wrAddr;
    logic                              wrEn;
    logic [hashCpuPkg::DATA_W-1:0]     wrData;
    logic [hashCpuPkg::DATA_W-1:0]     rdDataA;
    logic [hashCpuPkg::DATA_W-1:0]     rdDataB;
    logic [hashCpuPkg::DATA_W-1:0]     rdDataC;
    logic [hashCpuPkg::FUNC_W-1:0]     aluFunc;
    logic                              useImm;
    logic [hashCpuPkg::SHAMT_W-1:0]    shamt;
    logic [hashCpuPkg::DATA_W-1:0]     immExt;
    logic [hashCpuPkg::FUNC_W-1:0]     hashSel;
    logic [hashCpuPkg::DATA_W-1:0]     aluResult;
    logic [hashCpuPkg::DATA_W-1:0]     hashResult;

    hashCtrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .instrReq   (instrReq),
        .instr      (instr),
        .aluResult  (aluResult),
        .hashResult (hashResult),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdAddrC    (rdAddrC),
        .wrAddr     (wrAddr),
        .wrEn       (wrEn),
        .wrData     (wrData),
        .aluFunc    (aluFunc),
        .useImm     (useImm),
        .shamt      (shamt),
        .immExt     (immExt),
        .hashFunc   (hashSel),
        .instrAck   (instrAck),
        .result     (result)
    );

    regFile u_regFile (
        .clk     (clk),
        .reset   (reset),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdAddrC (rdAddrC), // Ru field for hash ops
        .wrAddr  (wrAddr),
        .wrEn    (wrEn),
        .wrData  (wrData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .rdDataC (rdDataC)
    );

    intAlu u_intAlu (
        .operandA  (rdDataA),
        .operandB  (rdDataB),
        .immExt    (immExt),
        .useImm    (useImm),
        .aluFunc   (aluFunc),
        .shamt     (shamt),
        .aluResult (aluResult)
    );

    hashFunc u_hashFunc (
        .dataX      (rdDataA),
        .dataY      (rdDataB),
        .dataZ      (rdDataC),
        .hashFunc   (hashSel),
        .hashResult (hashResult)
    );

endmodule

`default_nettype wire

// ==== rtl/hashCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hashCtrl (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic                              instrReq,
    input  wire hashCpuPkg::instr_u                instr,
    input  wire logic [hashCpuPkg::DATA_W-1:0]     aluResult,
    input  wire logic [hashCpuPkg::DATA_W-1:0]     hashResult,
    output logic [hashCpuPkg::REG_ADDR_W-1:0]      rdAddrA,
    output logic [hashCpuPkg::REG_ADDR_W-1:0]      rdAddrB,
    output logic [hashCpuPkg::REG_ADDR_W-1:0]      rdAddrC,
    output logic [hashCpuPkg::REG_ADDR_W-1:0]      wrAddr,
    output logic                                   wrEn,
    output logic [hashCpuPkg::DATA_W-1:0]          wrData,
    output logic [hashCpuPkg::FUNC_W-1:0]          aluFunc,
    output logic                                   useImm,
    output logic [hashCpuPkg::SHAMT_W-1:0]         shamt,
    output logic [hashCpuPkg::DATA_W-1:0]          immExt,
    output logic [hashCpuPkg::FUNC_W-1:0]          hashFunc,
    output logic                                   instrAck,
    output logic [hashCpuPkg::DATA_W-1:0]          result
);

    logic [hashCpuPkg::STATE_W-1:0] state;
    hashCpuPkg::instr_u             instrReg;
    logic                           selAlu;    // Result source is the ALU
    logic                           selHash;   // Result source is the hash unit
    logic [hashCpuPkg::DATA_W-1:0]  selResult;

    ////////////////////
    // Instruction capture
    ////////////////////
    always_ff @(posedge clk) begin
        if (state == hashCpuPkg::ST_IDLE && instrReq) begin
            instrReg <= instr; // Host holds instr while req is high
        end
    end

    ////////////////////
    // Decode
    ////////////////////
    assign rdAddrA = instrReg.rType.rs;
    assign rdAddrB = instrReg.rType.rt;
    assign rdAddrC = instrReg.rType.shamtRu; // Ru view of the field
    assign shamt   = instrReg.rType.shamtRu; // Shamt view of the same field
    assign immExt  = {{(hashCpuPkg::DATA_W - hashCpuPkg::IMM_W){
                          instrReg.iType.imm[hashCpuPkg::IMM_W-1]}},
                      instrReg.iType.imm};
    assign hashFunc = instrReg.rType.func;

    always_comb begin
        aluFunc = instrReg.rType.func;
        useImm  = 1'b0;
        selAlu  = 1'b0;
        selHash = 1'b0;
        wrAddr  = instrReg.rType.rd;
        case (instrReg.rType.opcode)
            hashCpuPkg::OP_RTYPE: begin
                selAlu = instrReg.rType.func inside {
                    hashCpuPkg::FN_ADD, hashCpuPkg::FN_SUB, hashCpuPkg::FN_AND,
                    hashCpuPkg::FN_OR,  hashCpuPkg::FN_XOR, hashCpuPkg::FN_SLT,
                    hashCpuPkg::FN_SLL, hashCpuPkg::FN_SRL};
            end
            hashCpuPkg::OP_ADDI: begin
                aluFunc = hashCpuPkg::FN_ADD; // Add with immediate operand
                useImm  = 1'b1;
                selAlu  = 1'b1;
                wrAddr  = instrReg.iType.rt;  // Destination is rt for I-type
            end
            hashCpuPkg::OP_HTYPE: begin
                selHash = instrReg.rType.func inside {
                    hashCpuPkg::FN_CH, hashCpuPkg::FN_MAJ, hashCpuPkg::FN_PAR};
            end
            default: begin
                selAlu  = 1'b0; // Unknown opcode, no result
                selHash = 1'b0;
            end
        endcase
    end

    // Unknown operations yield zero
    assign selResult = selAlu  ? aluResult  :
                       selHash ? hashResult : '0;

    assign wrData = selResult;
    assign wrEn   = (state == hashCpuPkg::ST_EXEC) && (selAlu || selHash); // One cycle only

    ////////////////////
    // Handshake FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= hashCpuPkg::ST_IDLE;
            instrAck <= 1'b0;
            result   <= '0;
        end else begin
            case (state)
                hashCpuPkg::ST_IDLE: begin
                    if (instrReq) begin
                        state <= hashCpuPkg::ST_EXEC;
                    end
                end
                hashCpuPkg::ST_EXEC: begin
                    result   <= selResult;
                    instrAck <= 1'b1;
                    state    <= hashCpuPkg::ST_DONE;
                end
                hashCpuPkg::ST_DONE: begin
                    if (!instrReq) begin
                        instrAck <= 1'b0; // Release seen
                        state    <= hashCpuPkg::ST_IDLE;
                    end
                end
                default: state <= hashCpuPkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic                              clk,
    input  wire logic                              reset,
    input  wire logic [hashCpuPkg::REG_ADDR_W-1:0] rdAddrA,
    input  wire logic [hashCpuPkg::REG_ADDR_W-1:0] rdAddrB,
    input  wire logic [hashCpuPkg::REG_ADDR_W-1:0] rdAddrC,
    input  wire logic [hashCpuPkg::REG_ADDR_W-1:0] wrAddr,
    input  wire logic                              wrEn,
    input  wire logic [hashCpuPkg::DATA_W-1:0]     wrData,
    output logic [hashCpuPkg::DATA_W-1:0]          rdDataA,
    output logic [hashCpuPkg::DATA_W-1:0]          rdDataB,
    output logic [hashCpuPkg::DATA_W-1:0]          rdDataC
);

    logic [hashCpuPkg::DATA_W-1:0] regs [0:hashCpuPkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < hashCpuPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData; // r0 is never written
        end
    end

    // Combinational read ports
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign rdDataC = regs[rdAddrC];

endmodule

`default_nettype wire

// ==== rtl/intAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input  wire logic [hashCpuPkg::DATA_W-1:0]  operandA,
    input  wire logic [hashCpuPkg::DATA_W-1:0]  operandB,
    input  wire logic [hashCpuPkg::DATA_W-1:0]  immExt,
    input  wire logic                           useImm,
    input  wire logic [hashCpuPkg::FUNC_W-1:0]  aluFunc,
    input  wire logic [hashCpuPkg::SHAMT_W-1:0] shamt,
    output logic [hashCpuPkg::DATA_W-1:0]       aluResult
);

    logic [hashCpuPkg::DATA_W-1:0] operandSel;
    logic                          shiftLeft;
    logic [hashCpuPkg::DATA_W-1:0] shiftStage [0:hashCpuPkg::SHAMT_W];
    logic [hashCpuPkg::DATA_W-1:0] shiftOut;

    function automatic logic [hashCpuPkg::DATA_W-1:0] bitReverse(
        input logic [hashCpuPkg::DATA_W-1:0] word
    );
        logic [hashCpuPkg::DATA_W-1:0] rev;
        for (int i = 0; i < hashCpuPkg::DATA_W; i++) begin
            rev[i] = word[hashCpuPkg::DATA_W-1-i];
        end
        return rev;
    endfunction

    assign operandSel = useImm ? immExt : operandB; // Immediate for addi
    assign shiftLeft  = (aluFunc == hashCpuPkg::FN_SLL);

    ////////////////////
    // Barrel shifter
    ////////////////////
    // Left shifts reuse the right-shift levels on a bit-reversed word
    assign shiftStage[0] = shiftLeft ? bitReverse(operandSel) : operandSel;

    for (genvar lvl = 0; lvl < hashCpuPkg::SHAMT_W; lvl++) begin : g_shiftLvl
        assign shiftStage[lvl+1] = shamt[lvl] ? (shiftStage[lvl] >> (1 << lvl))
                                              : shiftStage[lvl]; // Zero fill
    end

    assign shiftOut = shiftLeft ? bitReverse(shiftStage[hashCpuPkg::SHAMT_W])
                                : shiftStage[hashCpuPkg::SHAMT_W];

    always_comb begin
        case (aluFunc)
            hashCpuPkg::FN_ADD: aluResult = operandA + operandSel;
            hashCpuPkg::FN_SUB: aluResult = operandA - operandSel;
            hashCpuPkg::FN_AND: aluResult = operandA & operandSel;
            hashCpuPkg::FN_OR:  aluResult = operandA | operandSel;
            hashCpuPkg::FN_XOR: aluResult = operandA ^ operandSel;
            hashCpuPkg::FN_SLT: aluResult = {{(hashCpuPkg::DATA_W-1){1'b0}},
                                             $signed(operandA) < $signed(operandSel)};
            hashCpuPkg::FN_SLL,
            hashCpuPkg::FN_SRL: aluResult = shiftOut;
            default:            aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/hashFunc.sv ====
`timescale 1ns/1ps
`default_nettype none

module hashFunc (
    input  wire logic [hashCpuPkg::DATA_W-1:0] dataX,
    input  wire logic [hashCpuPkg::DATA_W-1:0] dataY,
    input  wire logic [hashCpuPkg::DATA_W-1:0] dataZ,
    input  wire logic [hashCpuPkg::FUNC_W-1:0] hashFunc,
    output logic [hashCpuPkg::DATA_W-1:0]      hashResult
);

    always_comb begin
        case (hashFunc)
            hashCpuPkg::FN_CH:  hashResult = (dataX & dataY) | (~dataX & dataZ); // X picks Y or Z
            hashCpuPkg::FN_MAJ: hashResult = (dataX & dataY) | (dataX & dataZ)
                                           | (dataY & dataZ);
            hashCpuPkg::FN_PAR: hashResult = dataX ^ dataY ^ dataZ;
            default:            hashResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== common/hashCpuPkg.sv ====
`default_nettype none

package hashCpuPkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNC_W     = 6;
    localparam int IMM_W      = 16;
    localparam int STATE_W    = 2;

    ////////////////////
    // Opcodes
    ////////////////////
    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'b001000;
    localparam logic [OPCODE_W-1:0] OP_HTYPE = 6'b011100;

    // R-type function codes
    localparam logic [FUNC_W-1:0] FN_SLL = 6'h00;
    localparam logic [FUNC_W-1:0] FN_SRL = 6'h02;
    localparam logic [FUNC_W-1:0] FN_ADD = 6'h20;
    localparam logic [FUNC_W-1:0] FN_SUB = 6'h22;
    localparam logic [FUNC_W-1:0] FN_AND = 6'h24;
    localparam logic [FUNC_W-1:0] FN_OR  = 6'h25;
    localparam logic [FUNC_W-1:0] FN_XOR = 6'h26;
    localparam logic [FUNC_W-1:0] FN_SLT = 6'h2a;

    // H-type function codes
    localparam logic [FUNC_W-1:0] FN_CH  = 6'h01;
    localparam logic [FUNC_W-1:0] FN_MAJ = 6'h02;
    localparam logic [FUNC_W-1:0] FN_PAR = 6'h03;

    // Controller states
    localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
    localparam logic [STATE_W-1:0] ST_EXEC = 2'd1;
    localparam logic [STATE_W-1:0] ST_DONE = 2'd2;

    ////////////////////
    // Instruction word
    ////////////////////
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [SHAMT_W-1:0]    shamtRu; // Shamt for R-type, ru for H-type
            logic [FUNC_W-1:0]     func;
        } rType;
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [IMM_W-1:0]      imm;
        } iType;
    } instr_u;

endpackage

`default_nettype wire
